// ==== hw/lsu_pkg.sv ====
// load/store unit core-side types
// addresses, data words, access size and the request/response bundles
// exchanged with the execute stage

package lsu_pkg;

  // byte address as computed by the execute stage
  typedef logic [31:0] addr_t;
  // one data word, little endian
  typedef logic [31:0] data_t;
  // byte position inside a word
  typedef logic [1:0]  offset_t;

  // access size, encoding kept from the core decoder
  // 2'b11 is not listed but decodes as a byte as well
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } lsu_size_e;

  // request from the execute stage, held until req_done
  typedef struct packed {
    logic      req;
    logic      we;
    lsu_size_e size;
    logic      sign_ext;
    addr_t     addr;
    data_t     wdata;
  } lsu_req_t;

  // result back to the core, flags are single-cycle strobes
  typedef struct packed {
    data_t rdata;
    logic  rdata_valid;
    logic  resp_valid;
    logic  load_err;
    logic  store_err;
  } lsu_rsp_t;

endpackage

// ==== hw/mem_bus_pkg.sv ====
// data memory bus types
// request/grant/response bus, one rvalid per grant, in order

package mem_bus_pkg;

  // one enable bit per byte lane
  typedef logic [3:0] be_t;

  // driven by the LSU, held stable until gnt
  typedef struct packed {
    logic           req;
    // always word aligned
    lsu_pkg::addr_t addr;
    logic           we;
    be_t            be;
    lsu_pkg::data_t wdata;
  } bus_req_t;

  // driven by memory
  typedef struct packed {
    logic           gnt;
    logic           rvalid;
    // qualified by rvalid
    logic           err;
    lsu_pkg::data_t rdata;
  } bus_rsp_t;

endpackage

// ==== hw/lsu_fsm.sv ====
// load/store unit control FSM
// sequences one or two bus transactions per access, tracks the misaligned
// second half, the first-half bus error and the last address for the trap value

`timescale 1ns/1ps

module lsu_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  lsu_pkg::lsu_req_t     lsu_req_i,
  input  mem_bus_pkg::bus_rsp_t bus_rsp_i,
  input  logic                  split_i,
  output logic                  bus_req_valid_o,
  output logic                  addr_incr_req_o,
  output lsu_pkg::addr_t        addr_last_o,
  output logic                  req_done_o,
  output logic                  busy_o,
  output logic                  ctrl_update_o,
  output logic                  rdata_update_o,
  output logic                  second_half_o,
  output logic                  resp_valid_o,
  output logic                  rdata_valid_o,
  output logic                  load_err_o,
  output logic                  store_err_o
);

  import lsu_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID_MIS_GNTS_DONE
  } ls_state_e;

  ls_state_e state_q, state_d;

  // high once the first half of a split access is granted
  logic  mis_q, mis_d;
  // bus error seen on the first half
  logic  err_q, err_d;
  // write flag of the access in flight
  logic  we_q;
  logic  addr_update;
  logic  err_any;
  addr_t addr_w_aligned;
  addr_t addr_last_d, addr_last_q;

  assign addr_w_aligned = {lsu_req_i.addr[31:2], 2'b00};

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    mis_d           = mis_q;
    err_d           = err_q;
    bus_req_valid_o = 1'b0;
    addr_incr_req_o = 1'b0;
    addr_update     = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (lsu_req_i.req) begin
          bus_req_valid_o = 1'b1;
          err_d           = 1'b0;
          if (bus_rsp_i.gnt) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            mis_d         = split_i;
            state_d       = split_i ? WAIT_RVALID_MIS : IDLE;
          end else begin
            state_d       = split_i ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        bus_req_valid_o = 1'b1;
        if (bus_rsp_i.gnt) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          mis_d         = 1'b1;
          state_d       = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        // second request goes out, core moves to the next word
        bus_req_valid_o = 1'b1;
        addr_incr_req_o = 1'b1;
        if (bus_rsp_i.rvalid) begin
          err_d          = bus_rsp_i.err;
          // keep the upper bytes of the first word for loads
          rdata_update_o = ~we_q;
          state_d        = bus_rsp_i.gnt ? IDLE : WAIT_GNT;
          // a failing first half keeps its own address for the trap
          addr_update    = bus_rsp_i.gnt & ~bus_rsp_i.err;
          mis_d          = ~bus_rsp_i.gnt;
        end else if (bus_rsp_i.gnt) begin
          // both requests granted, first rvalid still outstanding
          state_d = WAIT_RVALID_MIS_GNTS_DONE;
          mis_d   = 1'b0;
        end
      end

      WAIT_GNT: begin
        addr_incr_req_o = mis_q;
        bus_req_valid_o = 1'b1;
        if (bus_rsp_i.gnt) begin
          ctrl_update_o = 1'b1;
          addr_update   = ~err_q;
          mis_d         = 1'b0;
          state_d       = IDLE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        // core still holds the second address for addr_last
        addr_incr_req_o = 1'b1;
        if (bus_rsp_i.rvalid) begin
          err_d          = bus_rsp_i.err;
          addr_update    = ~bus_rsp_i.err;
          rdata_update_o = ~we_q;
          state_d        = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // second half of a split access records the word it targets
  assign addr_last_d = addr_incr_req_o ? addr_w_aligned : lsu_req_i.addr;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      mis_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      mis_q   <= mis_d;
      err_q   <= err_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else if (ctrl_update_o) begin
      we_q <= lsu_req_i.we;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= addr_last_d;
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  // done once no further bus request is needed
  assign req_done_o    = (lsu_req_i.req | (state_q != IDLE)) & (state_d == IDLE);
  assign busy_o        = (state_q != IDLE);
  assign second_half_o = mis_q;
  assign addr_last_o   = addr_last_q;

  // either half failing fails the whole access
  assign err_any       = err_q | bus_rsp_i.err;
  // last rvalid of an access arrives with the FSM back in IDLE
  assign resp_valid_o  = bus_rsp_i.rvalid & (state_q == IDLE);
  assign rdata_valid_o = resp_valid_o & ~err_any & ~we_q;
  assign load_err_o    = resp_valid_o & err_any & ~we_q;
  assign store_err_o   = resp_valid_o & err_any & we_q;

  // state register only ever holds one of the five encodings
  a_state_legal : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q inside {IDLE, WAIT_GNT_MIS, WAIT_RVALID_MIS, WAIT_GNT, WAIT_RVALID_MIS_GNTS_DONE}
  ) else $error("lsu_fsm in illegal state");

  // granted second request must target the word right after the first one
  a_second_word : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (bus_req_valid_o && addr_incr_req_o && bus_rsp_i.gnt) |->
      (lsu_req_i.addr[31:2] == addr_last_q[31:2] + 30'd1)
  ) else $error("second half of split access not at next word");

endmodule

// ==== hw/lsu_store_align.sv ====
// store-side datapath of the load/store unit
// byte enables per size and offset, write data lane rotation, split decision

`timescale 1ns/1ps

module lsu_store_align (
  input  lsu_pkg::lsu_req_t lsu_req_i,
  input  logic              second_half_i,
  output logic              split_o,
  output mem_bus_pkg::be_t  be_o,
  output lsu_pkg::data_t    wdata_o
);

  import lsu_pkg::*;
  import mem_bus_pkg::*;

  offset_t offset;
  be_t     be_word;
  be_t     be_half;
  be_t     be_byte;

  // offset stays the same on both halves, the core adds 4 to the address
  assign offset = lsu_req_i.addr[1:0];

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb begin
    if (!second_half_i) begin
      // first word, lanes from offset upward
      unique case (offset)
        2'b00:   be_word = 4'b1111;
        2'b01:   be_word = 4'b1110;
        2'b10:   be_word = 4'b1100;
        default: be_word = 4'b1000;
      endcase
    end else begin
      // spill into the low lanes of the next word
      unique case (offset)
        2'b01:   be_word = 4'b0001;
        2'b10:   be_word = 4'b0011;
        2'b11:   be_word = 4'b0111;
        default: be_word = 4'b0000;
      endcase
    end
  end

  always_comb begin
    if (!second_half_i) begin
      unique case (offset)
        2'b00:   be_half = 4'b0011;
        2'b01:   be_half = 4'b0110;
        2'b10:   be_half = 4'b1100;
        default: be_half = 4'b1000;
      endcase
    end else begin
      // only offset 3 splits, upper byte lands in lane 0
      be_half = 4'b0001;
    end
  end

  assign be_byte = be_t'(4'b0001 << offset);

  always_comb begin
    case (lsu_req_i.size)
      SIZE_WORD: be_o = be_word;
      SIZE_HALF: be_o = be_half;
      // 2'b10 and 2'b11 are both bytes
      default:   be_o = be_byte;
    endcase
  end

  // rotate so byte 0 of the store data sits in lane offset
  always_comb begin
    unique case (offset)
      2'b00:   wdata_o = lsu_req_i.wdata;
      2'b01:   wdata_o = {lsu_req_i.wdata[23:0], lsu_req_i.wdata[31:24]};
      2'b10:   wdata_o = {lsu_req_i.wdata[15:0], lsu_req_i.wdata[31:16]};
      default: wdata_o = {lsu_req_i.wdata[7:0], lsu_req_i.wdata[31:8]};
    endcase
  end

  // accesses that cross a word boundary need two bus transactions
  assign split_o = ((lsu_req_i.size == SIZE_WORD) && (offset != 2'b00)) ||
                   ((lsu_req_i.size == SIZE_HALF) && (offset == 2'b11));

  // every request phase, first or second half, writes or reads some lane
  always_comb begin
    if (lsu_req_i.req) begin
      a_be_nonzero : assert final (be_o != '0)
        else $error("byte enables empty during request");
    end
  end

endmodule

// ==== hw/lsu_load_align.sv ====
// load-side datapath of the load/store unit
// keeps the access attributes and the upper bytes of a first read word,
// then realigns the returned data and zero- or sign-extends halves and bytes

`timescale 1ns/1ps

module lsu_load_align (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  lsu_pkg::lsu_req_t lsu_req_i,
  input  logic              ctrl_update_i,
  input  logic              rdata_update_i,
  input  lsu_pkg::data_t    rdata_i,
  output lsu_pkg::data_t    rdata_o
);

  import lsu_pkg::*;

  offset_t     offset_q;
  lsu_size_e   size_q;
  logic        sign_ext_q;
  // bytes 1..3 of the first word of a split load
  logic [23:0] upper_q;

  data_t       word_ext;
  logic [15:0] half_raw;
  logic [7:0]  byte_raw;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  // attributes taken at grant, response comes later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      size_q     <= SIZE_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= lsu_req_i.addr[1:0];
      size_q     <= lsu_req_i.size;
      sign_ext_q <= lsu_req_i.sign_ext;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      upper_q <= rdata_i[31:8];
    end
  end

  //////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////

  // low bytes of the new word complete the held upper bytes
  always_comb begin
    unique case (offset_q)
      2'b00:   word_ext = rdata_i;
      2'b01:   word_ext = {rdata_i[7:0], upper_q[23:0]};
      2'b10:   word_ext = {rdata_i[15:0], upper_q[23:8]};
      default: word_ext = {rdata_i[23:0], upper_q[23:16]};
    endcase
  end

  always_comb begin
    unique case (offset_q)
      2'b00:   half_raw = rdata_i[15:0];
      2'b01:   half_raw = rdata_i[23:8];
      2'b10:   half_raw = rdata_i[31:16];
      // crosses the word, upper byte from the second word
      default: half_raw = {rdata_i[7:0], upper_q[23:16]};
    endcase
  end

  always_comb begin
    unique case (offset_q)
      2'b00:   byte_raw = rdata_i[7:0];
      2'b01:   byte_raw = rdata_i[15:8];
      2'b10:   byte_raw = rdata_i[23:16];
      default: byte_raw = rdata_i[31:24];
    endcase
  end

  // extend with the sign bit only when asked
  always_comb begin
    case (size_q)
      SIZE_WORD: rdata_o = word_ext;
      SIZE_HALF: rdata_o = {{16{sign_ext_q & half_raw[15]}}, half_raw};
      default:   rdata_o = {{24{sign_ext_q & byte_raw[7]}}, byte_raw};
    endcase
  end

  // size selects the output mux on every response
  a_size_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(size_q)
  ) else $error("registered load size unknown");

endmodule

// ==== hw/lsu_top.sv ====
// load/store unit top level
// joins the control FSM and the store/load datapaths, packs the core
// and data bus structs

`timescale 1ns/1ps

module lsu_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // core side, held until req_done_o
  // during addr_incr_req_o the core presents the first address plus 4
  input  lsu_pkg::lsu_req_t     lsu_req_i,
  output lsu_pkg::lsu_rsp_t     lsu_rsp_o,
  // data memory bus
  output mem_bus_pkg::bus_req_t bus_req_o,
  input  mem_bus_pkg::bus_rsp_t bus_rsp_i,
  output logic                  addr_incr_req_o,
  output lsu_pkg::addr_t        addr_last_o,
  output logic                  req_done_o,
  output logic                  busy_o
);

  import lsu_pkg::*;
  import mem_bus_pkg::*;

  logic  bus_req_valid;
  logic  split;
  logic  ctrl_update;
  logic  rdata_update;
  logic  second_half;
  logic  resp_valid;
  logic  rdata_valid;
  logic  load_err;
  logic  store_err;
  be_t   be;
  data_t wdata;
  data_t rdata;

  lsu_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lsu_req_i       (lsu_req_i),
    .bus_rsp_i       (bus_rsp_i),
    .split_i         (split),
    .bus_req_valid_o (bus_req_valid),
    .addr_incr_req_o (addr_incr_req_o),
    .addr_last_o     (addr_last_o),
    .req_done_o      (req_done_o),
    .busy_o          (busy_o),
    .ctrl_update_o   (ctrl_update),
    .rdata_update_o  (rdata_update),
    .second_half_o   (second_half),
    .resp_valid_o    (resp_valid),
    .rdata_valid_o   (rdata_valid),
    .load_err_o      (load_err),
    .store_err_o     (store_err)
  );

  lsu_store_align u_store_align (
    .lsu_req_i     (lsu_req_i),
    .second_half_i (second_half),
    .split_o       (split),
    .be_o          (be),
    .wdata_o       (wdata)
  );

  lsu_load_align u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_req_i      (lsu_req_i),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .rdata_i        (bus_rsp_i.rdata),
    .rdata_o        (rdata)
  );

  // bus always sees the word address, lanes chosen by be
  assign bus_req_o.req   = bus_req_valid;
  assign bus_req_o.addr  = {lsu_req_i.addr[31:2], 2'b00};
  assign bus_req_o.we    = lsu_req_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata;

  assign lsu_rsp_o.rdata       = rdata;
  assign lsu_rsp_o.rdata_valid = rdata_valid;
  assign lsu_rsp_o.resp_valid  = resp_valid;
  assign lsu_rsp_o.load_err    = load_err;
  assign lsu_rsp_o.store_err   = store_err;

endmodule

// ==== bench/lsu_tb.sv ====
// testbench for the load/store unit
// table of loads and stores against a 16-word memory model with random grant delay

`timescale 1ns/1ps

module lsu_tb;

  import lsu_pkg::*;
  import mem_bus_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_ROWS   = 29;

  // one table row, expected values from little-endian byte lanes
  typedef struct packed {
    logic      we;
    lsu_size_e size;
    addr_t     addr;
    data_t     wdata;
    logic      sign_ext;
    data_t     rdata;
    logic      err;
    // access crosses a word boundary
    logic      incr;
  } row_t;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  lsu_req_t lsu_req;
  lsu_rsp_t lsu_rsp;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  logic     addr_incr_req;
  addr_t    addr_last;
  logic     req_done;
  logic     busy;

  // memory model state
  data_t       mem [16];
  logic        mem_gnt;
  logic        mem_rvalid;
  logic        mem_err;
  data_t       mem_rdata;
  int          gnt_wait;
  logic [15:0] lfsr_q;

  row_t rows [NUM_ROWS];
  int   n_checks = 0;
  int   n_errors = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  lsu_top dut_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lsu_req_i       (lsu_req),
    .lsu_rsp_o       (lsu_rsp),
    .bus_req_o       (bus_req),
    .bus_rsp_i       (bus_rsp),
    .addr_incr_req_o (addr_incr_req),
    .addr_last_o     (addr_last),
    .req_done_o      (req_done),
    .busy_o          (busy)
  );

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  // grant as soon as the drawn wait has run out
  assign mem_gnt = bus_req.req && (gnt_wait == 0);
  assign bus_rsp = {mem_gnt, mem_rvalid, mem_err, mem_rdata};

  // galois lfsr, taps for a maximal 16-bit sequence
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // two lfsr bits give 0..3, the value 3 folds onto 1
  task automatic draw_delay(output int d);
    logic [1:0] v;
    for (int k = 0; k < 2; k++) begin
      v[k]   = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
    d = (v == 2'd3) ? 1 : int'(v);
  endtask

  initial begin
    bus_req_t   breq;
    logic       granted;
    logic [3:0] idx;
    for (int i = 0; i < 16; i++) begin
      mem[i] = 32'hA5C3_0000 ^ (32'(i) * 32'h0103_0507);
    end
    mem_rvalid = 1'b0;
    mem_err    = 1'b0;
    mem_rdata  = '0;
    lfsr_q     = 16'd28;
    draw_delay(gnt_wait);
    forever begin
      @(posedge clk_i);
      breq    = bus_req;
      granted = bus_req.req && mem_gnt;
      #10;
      mem_rvalid = 1'b0;
      mem_err    = 1'b0;
      mem_rdata  = '0;
      // response one cycle after the grant
      if (granted) begin
        idx        = breq.addr[5:2];
        mem_rvalid = 1'b1;
        if (idx == 4'd15) begin
          mem_err = 1'b1;
        end else if (breq.we) begin
          for (int b = 0; b < 4; b++) begin
            if (breq.be[b]) begin
              mem[idx][8*b +: 8] = breq.wdata[8*b +: 8];
            end
          end
        end else begin
          mem_rdata = mem[idx];
        end
        draw_delay(gnt_wait);
      end else if (breq.req && gnt_wait > 0) begin
        gnt_wait = gnt_wait - 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic check_data(input string what, input data_t got, input data_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // nothing pending on the bus or towards the core
  task automatic check_idle(input string when);
    check_flag({when, " busy"}, busy, 1'b0);
    check_flag({when, " bus req"}, bus_req.req, 1'b0);
    check_flag({when, " addr_incr_req"}, addr_incr_req, 1'b0);
    check_flag({when, " req_done"}, req_done, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  function automatic row_t make_row(input logic we, input lsu_size_e size, input addr_t addr,
                                    input data_t wdata, input logic sign_ext,
                                    input data_t rdata, input logic err, input logic incr);
    make_row = {we, size, addr, wdata, sign_ext, rdata, err, incr};
  endfunction

  task automatic load_table();
    rows[0]  = make_row(1, SIZE_WORD, 32'h00, 32'h1122_3344, 0, 32'h0, 0, 0);
    rows[1]  = make_row(0, SIZE_WORD, 32'h00, 32'h0, 0, 32'h1122_3344, 0, 0);
    rows[2]  = make_row(0, SIZE_BYTE, 32'h03, 32'h0, 0, 32'h0000_0011, 0, 0);
    rows[3]  = make_row(0, SIZE_HALF, 32'h02, 32'h0, 1, 32'h0000_1122, 0, 0);
    rows[4]  = make_row(1, SIZE_HALF, 32'h06, 32'h0000_BEEF, 0, 32'h0, 0, 0);
    rows[5]  = make_row(0, SIZE_HALF, 32'h06, 32'h0, 0, 32'h0000_BEEF, 0, 0);
    rows[6]  = make_row(0, SIZE_HALF, 32'h06, 32'h0, 1, 32'hFFFF_BEEF, 0, 0);
    rows[7]  = make_row(1, SIZE_BYTE, 32'h09, 32'h0000_0080, 0, 32'h0, 0, 0);
    rows[8]  = make_row(0, SIZE_BYTE, 32'h09, 32'h0, 0, 32'h0000_0080, 0, 0);
    rows[9]  = make_row(0, SIZE_BYTE, 32'h09, 32'h0, 1, 32'hFFFF_FF80, 0, 0);
    rows[10] = make_row(1, SIZE_BYTE, 32'h0B, 32'h0000_007F, 0, 32'h0, 0, 0);
    rows[11] = make_row(0, SIZE_BYTE, 32'h0B, 32'h0, 1, 32'h0000_007F, 0, 0);
    // encoding 3 is a byte as well
    rows[12] = make_row(0, lsu_size_e'(2'b11), 32'h0B, 32'h0, 0, 32'h0000_007F, 0, 0);
    // misaligned words at offsets 1, 2 and 3
    rows[13] = make_row(1, SIZE_WORD, 32'h11, 32'hCAFE_F00D, 0, 32'h0, 0, 1);
    rows[14] = make_row(0, SIZE_WORD, 32'h11, 32'h0, 0, 32'hCAFE_F00D, 0, 1);
    rows[15] = make_row(1, SIZE_WORD, 32'h1A, 32'hDEAD_BEEF, 0, 32'h0, 0, 1);
    rows[16] = make_row(0, SIZE_WORD, 32'h1A, 32'h0, 0, 32'hDEAD_BEEF, 0, 1);
    rows[17] = make_row(1, SIZE_WORD, 32'h27, 32'h0123_4567, 0, 32'h0, 0, 1);
    rows[18] = make_row(0, SIZE_WORD, 32'h27, 32'h0, 0, 32'h0123_4567, 0, 1);
    // bytes of the spilled part land in the next word
    rows[19] = make_row(0, SIZE_BYTE, 32'h28, 32'h0, 0, 32'h0000_0045, 0, 0);
    rows[20] = make_row(0, SIZE_HALF, 32'h29, 32'h0, 1, 32'h0000_0123, 0, 0);
    // half word across the boundary
    rows[21] = make_row(1, SIZE_HALF, 32'h33, 32'h0000_A55A, 0, 32'h0, 0, 1);
    rows[22] = make_row(0, SIZE_HALF, 32'h33, 32'h0, 1, 32'hFFFF_A55A, 0, 1);
    rows[23] = make_row(0, SIZE_HALF, 32'h33, 32'h0, 0, 32'h0000_A55A, 0, 1);
    // word 15 answers with a bus error
    rows[24] = make_row(1, SIZE_WORD, 32'h3C, 32'h1234_5678, 0, 32'h0, 1, 0);
    rows[25] = make_row(0, SIZE_WORD, 32'h3C, 32'h0, 0, 32'h0, 1, 0);
    rows[26] = make_row(0, SIZE_BYTE, 32'h3D, 32'h0, 0, 32'h0, 1, 0);
    rows[27] = make_row(0, SIZE_WORD, 32'h3A, 32'h0, 0, 32'h0, 1, 1);
    rows[28] = make_row(1, SIZE_HALF, 32'h3B, 32'h0000_FFFF, 0, 32'h0, 1, 1);
  endtask

  // core side, starts a fixed delay after a rising edge
  task automatic apply_row(input int n, input row_t r);
    logic     done;
    logic     resp;
    logic     incr_seen;
    lsu_rsp_t rsp;
    string    tag;
    done      = 1'b0;
    resp      = 1'b0;
    incr_seen = 1'b0;
    tag       = $sformatf("row %0d", n);
    lsu_req.req      = 1'b1;
    lsu_req.we       = r.we;
    lsu_req.size     = r.size;
    lsu_req.sign_ext = r.sign_ext;
    lsu_req.addr     = r.addr;
    lsu_req.wdata    = r.wdata;
    // hold the request until done, next word while the FSM asks for it
    while (!done) begin
      lsu_req.addr = addr_incr_req ? r.addr + 32'd4 : r.addr;
      // outputs of this cycle are settled by the falling edge
      @(negedge clk_i);
      done      = req_done;
      incr_seen = incr_seen | addr_incr_req;
      @(posedge clk_i);
      #10;
    end
    lsu_req.req = 1'b0;
    while (!resp) begin
      @(negedge clk_i);
      rsp  = lsu_rsp;
      resp = rsp.resp_valid;
      if (resp) begin
        check_flag({tag, " load_err"}, rsp.load_err, r.err & ~r.we);
        check_flag({tag, " store_err"}, rsp.store_err, r.err & r.we);
        check_flag({tag, " rdata_valid"}, rsp.rdata_valid, ~r.err & ~r.we);
        if (!r.we && !r.err) begin
          check_data({tag, " rdata"}, rsp.rdata, r.rdata);
        end
        check_flag({tag, " addr_incr_req seen"}, incr_seen, r.incr);
        if (!r.incr) begin
          check_addr({tag, " addr_last"}, addr_last, r.addr);
        end
        check_idle({tag, " after response"});
      end
    end
    @(posedge clk_i);
    #10;
  endtask

  //////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////

  initial begin
    lsu_req = '0;
    rst_ni  = 1'b0;
    load_table();
    repeat (3) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(posedge clk_i);
    check_idle("after reset");
    check_flag("after reset resp_valid", lsu_rsp.resp_valid, 1'b0);
    check_flag("after reset rdata_valid", lsu_rsp.rdata_valid, 1'b0);
    check_flag("after reset load_err", lsu_rsp.load_err, 1'b0);
    check_flag("after reset store_err", lsu_rsp.store_err, 1'b0);
    #10;
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(i, rows[i]);
    end
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // each row gets 20 cycles, plus the reset phase
  initial begin
    #(CLK_PERIOD * (NUM_ROWS * 20 + 4));
    $display("timeout, the table did not finish within %0d cycles", NUM_ROWS * 20 + 4);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/lsu_pkg.sv
hw/mem_bus_pkg.sv
hw/lsu_fsm.sv
hw/lsu_store_align.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
bench/lsu_tb.sv

// ==== Makefile ====
TOP := lsu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
